//--- hdl/riscvPkg.sv
`default_nettype none

package riscvPkg;

    localparam int xlen = 32; // data path width

    // opcodes, bits 6:0 of the instruction
    localparam logic [6:0] opRType  = 7'b0110011;
    localparam logic [6:0] opIType  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    // alu class from the main decoder
    localparam logic [2:0] classR      = 3'd0;
    localparam logic [2:0] classI      = 3'd1;
    localparam logic [2:0] classLoad   = 3'd2;
    localparam logic [2:0] classStore  = 3'd3;
    localparam logic [2:0] classBranch = 3'd4;
    localparam logic [2:0] classJump   = 3'd5; // jal and jalr
    localparam logic [2:0] classLui    = 3'd6;
    localparam logic [2:0] classAuipc  = 3'd7;

    localparam logic [3:0] aluAdd  = 4'd0;
    localparam logic [3:0] aluSub  = 4'd1;
    localparam logic [3:0] aluSll  = 4'd2;
    localparam logic [3:0] aluSlt  = 4'd3;
    localparam logic [3:0] aluSltu = 4'd4;
    localparam logic [3:0] aluXor  = 4'd5;
    localparam logic [3:0] aluSrl  = 4'd6;
    localparam logic [3:0] aluSra  = 4'd7;
    localparam logic [3:0] aluOr   = 4'd8;
    localparam logic [3:0] aluAnd  = 4'd9;

    localparam logic [2:0] immI = 3'd0;
    localparam logic [2:0] immS = 3'd1;
    localparam logic [2:0] immB = 3'd2;
    localparam logic [2:0] immU = 3'd3;
    localparam logic [2:0] immJ = 3'd4;

    localparam logic [1:0] resAlu     = 2'd0;
    localparam logic [1:0] resLoad    = 2'd1;
    localparam logic [1:0] resPcPlus4 = 2'd2; // link value
    localparam logic [1:0] resImm     = 2'd3; // lui

    localparam logic [1:0] pcSeq  = 2'b00;
    localparam logic [1:0] pcRel  = 2'b01; // branch taken, jal
    localparam logic [1:0] pcJalr = 2'b11;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instrWord;

endpackage

`default_nettype wire

//--- hdl/ctrlIf.sv
`default_nettype none

interface ctrlIf;
    logic [2:0] aluClass;  // coarse alu class
    logic       aluSrc;    // srcB from immediate
    logic [2:0] immFmt;
    logic [1:0] resultSrc;
    logic       regWrite;
    logic       memWrite;
    logic       aluASrcPc; // srcA from pc

    modport ctrl (
        output aluClass, aluSrc, immFmt, resultSrc, regWrite, memWrite, aluASrcPc
    );

    modport dp (
        input aluClass, aluSrc, immFmt, resultSrc, regWrite, memWrite, aluASrcPc
    );
endinterface

`default_nettype wire

//--- hdl/controlUnit.sv
`default_nettype none

module controlUnit (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       zeroFlag,
    input  logic       negativeFlag, // signed less
    input  logic       unsignedLess,
    input  logic       rstN,
    ctrlIf.ctrl        ctrl,
    output logic [1:0] pcSrc
);

    logic regWriteDec;
    logic memWriteDec;
    logic takeBranch;

    // branch condition from srcA - srcB flags
    always_comb begin
        case (funct3)
            3'b000:  takeBranch = zeroFlag;      // beq
            3'b001:  takeBranch = ~zeroFlag;     // bne
            3'b100:  takeBranch = negativeFlag;  // blt
            3'b101:  takeBranch = ~negativeFlag; // bge
            3'b110:  takeBranch = unsignedLess;  // bltu
            3'b111:  takeBranch = ~unsignedLess; // bgeu
            default: takeBranch = 1'b0;
        endcase
    end

    always_comb begin
        ctrl.aluClass  = riscvPkg::classR;
        ctrl.aluSrc    = 1'b0;
        ctrl.immFmt    = riscvPkg::immI;
        ctrl.resultSrc = riscvPkg::resAlu;
        ctrl.aluASrcPc = 1'b0;
        regWriteDec    = 1'b0;
        memWriteDec    = 1'b0;
        pcSrc          = riscvPkg::pcSeq;
        case (opcode)
            riscvPkg::opRType: begin
                regWriteDec = 1'b1; // rs1 op rs2
            end
            riscvPkg::opIType: begin
                ctrl.aluClass = riscvPkg::classI;
                ctrl.aluSrc   = 1'b1;
                regWriteDec   = 1'b1;
            end
            riscvPkg::opLoad: begin
                ctrl.aluClass  = riscvPkg::classLoad;
                ctrl.aluSrc    = 1'b1; // rs1 + offset
                ctrl.resultSrc = riscvPkg::resLoad;
                regWriteDec    = 1'b1;
            end
            riscvPkg::opStore: begin
                ctrl.aluClass = riscvPkg::classStore;
                ctrl.aluSrc   = 1'b1;
                ctrl.immFmt   = riscvPkg::immS;
                memWriteDec   = 1'b1;
            end
            riscvPkg::opBranch: begin
                ctrl.aluClass = riscvPkg::classBranch; // compares rs1 with rs2
                ctrl.immFmt   = riscvPkg::immB;
                pcSrc         = takeBranch ? riscvPkg::pcRel : riscvPkg::pcSeq;
            end
            riscvPkg::opJal: begin
                ctrl.aluClass  = riscvPkg::classJump;
                ctrl.aluSrc    = 1'b1;
                ctrl.aluASrcPc = 1'b1;
                ctrl.immFmt    = riscvPkg::immJ;
                ctrl.resultSrc = riscvPkg::resPcPlus4;
                regWriteDec    = 1'b1;
                pcSrc          = riscvPkg::pcRel;
            end
            riscvPkg::opJalr: begin
                ctrl.aluClass  = riscvPkg::classJump;
                ctrl.aluSrc    = 1'b1; // rs1 + imm is the target
                ctrl.resultSrc = riscvPkg::resPcPlus4;
                regWriteDec    = 1'b1;
                pcSrc          = riscvPkg::pcJalr;
            end
            riscvPkg::opLui: begin
                ctrl.aluClass  = riscvPkg::classLui;
                ctrl.aluSrc    = 1'b1;
                ctrl.immFmt    = riscvPkg::immU;
                ctrl.resultSrc = riscvPkg::resImm; // imm straight through
                regWriteDec    = 1'b1;
            end
            riscvPkg::opAuipc: begin
                ctrl.aluClass  = riscvPkg::classAuipc;
                ctrl.aluSrc    = 1'b1;
                ctrl.aluASrcPc = 1'b1; // pc + imm
                ctrl.immFmt    = riscvPkg::immU;
                regWriteDec    = 1'b1;
            end
            default: ; // unsupported opcodes act as nop
        endcase
    end

    // no state changes while held in reset
    assign ctrl.regWrite = regWriteDec & rstN;
    assign ctrl.memWrite = memWriteDec & rstN;

    always_comb begin
        assert (!(ctrl.regWrite && ctrl.memWrite))
            else $error("regWrite and memWrite both active, opcode %h", opcode);
    end

endmodule

`default_nettype wire

//--- hdl/aluDecoder.sv
`default_nettype none

module aluDecoder (
    ctrlIf.dp          dp,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       opBit5, // set for R-type only
    output logic [3:0] aluOp
);

    always_comb begin
        case (dp.aluClass)
            riscvPkg::classR, riscvPkg::classI: begin
                case (funct3)
                    // addi has no sub form, imm bit 5 is data
                    3'b000:  aluOp = (opBit5 & funct7b5) ? riscvPkg::aluSub : riscvPkg::aluAdd;
                    3'b001:  aluOp = riscvPkg::aluSll;
                    3'b010:  aluOp = riscvPkg::aluSlt;
                    3'b011:  aluOp = riscvPkg::aluSltu;
                    3'b100:  aluOp = riscvPkg::aluXor;
                    3'b101:  aluOp = funct7b5 ? riscvPkg::aluSra : riscvPkg::aluSrl;
                    3'b110:  aluOp = riscvPkg::aluOr;
                    default: aluOp = riscvPkg::aluAnd;
                endcase
            end
            riscvPkg::classBranch: begin
                aluOp = funct3[1] ? riscvPkg::aluSltu : riscvPkg::aluSub; // bltu/bgeu
            end
            default: aluOp = riscvPkg::aluAdd; // addresses, lui, auipc
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

module alu (
    input  logic [riscvPkg::xlen-1:0] srcA,
    input  logic [riscvPkg::xlen-1:0] srcB,
    input  logic [3:0]                aluOp,
    output logic [riscvPkg::xlen-1:0] result,
    output logic                      zeroFlag,
    output logic                      negativeFlag,
    output logic                      unsignedLess
);

    logic [riscvPkg::xlen:0] diff; // extra bit is the borrow
    logic                    overflow;
    logic [4:0]              shamt;

    assign diff     = {1'b0, srcA} - {1'b0, srcB};
    assign shamt    = srcB[4:0];
    // signed overflow on subtract
    assign overflow = (srcA[riscvPkg::xlen-1] != srcB[riscvPkg::xlen-1]) &&
                      (diff[riscvPkg::xlen-1] != srcA[riscvPkg::xlen-1]);

    assign zeroFlag     = (diff[riscvPkg::xlen-1:0] == '0);
    assign negativeFlag = diff[riscvPkg::xlen-1] ^ overflow; // signed a < b
    assign unsignedLess = diff[riscvPkg::xlen];              // borrow out

    always_comb begin
        case (aluOp)
            riscvPkg::aluAdd:  result = srcA + srcB;
            riscvPkg::aluSub:  result = diff[riscvPkg::xlen-1:0];
            riscvPkg::aluSll:  result = srcA << shamt;
            riscvPkg::aluSlt:  result = {{(riscvPkg::xlen-1){1'b0}}, negativeFlag};
            riscvPkg::aluSltu: result = {{(riscvPkg::xlen-1){1'b0}}, unsignedLess};
            riscvPkg::aluXor:  result = srcA ^ srcB;
            riscvPkg::aluSrl:  result = srcA >> shamt;
            riscvPkg::aluSra:  result = $unsigned($signed(srcA) >>> shamt);
            riscvPkg::aluOr:   result = srcA | srcB;
            riscvPkg::aluAnd:  result = srcA & srcB;
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`default_nettype none

module regFile (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [4:0]                rs1,
    input  logic [4:0]                rs2,
    input  logic [4:0]                rd,
    input  logic                      we,
    input  logic [riscvPkg::xlen-1:0] wdata,
    output logic [riscvPkg::xlen-1:0] rdata1,
    output logic [riscvPkg::xlen-1:0] rdata2
);

    logic [riscvPkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int idx = 0; idx < 32; idx++) begin
                regs[idx] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    // x0 must read zero whatever was written before
    assert property (@(posedge clk) disable iff (!rstN) (rs1 == 5'd0) |-> (rdata1 == '0))
        else $error("x0 read on port 1 returned %h", rdata1);
    assert property (@(posedge clk) disable iff (!rstN) (rs2 == 5'd0) |-> (rdata2 == '0))
        else $error("x0 read on port 2 returned %h", rdata2);

endmodule

`default_nettype wire

//--- hdl/immGen.sv
`default_nettype none

module immGen (
    input  riscvPkg::instrWord        instr,
    ctrlIf.dp                         dp,
    output logic [riscvPkg::xlen-1:0] imm
);

    always_comb begin
        case (dp.immFmt)
            riscvPkg::immI: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            riscvPkg::immS: imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            riscvPkg::immB: begin
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10to5, instr.b.imm4to1, 1'b0}; // halfword offset
            end
            riscvPkg::immU: imm = {instr.u.imm, 12'b0};
            riscvPkg::immJ: begin
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                       instr.j.imm11, instr.j.imm10to1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/pcUnit.sv
`default_nettype none

module pcUnit (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [1:0]                pcSrc,
    input  logic [riscvPkg::xlen-1:0] imm,
    input  logic [riscvPkg::xlen-1:0] jalrBase, // rs1 + imm from the alu
    output logic [riscvPkg::xlen-1:0] pc,
    output logic [riscvPkg::xlen-1:0] pcPlus4
);

    logic [riscvPkg::xlen-1:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (pcSrc)
            riscvPkg::pcRel:  nextPc = pc + imm;
            riscvPkg::pcJalr: nextPc = {jalrBase[riscvPkg::xlen-1:1], 1'b0}; // lsb dropped
            default:          nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // targets from branch, jal and jalr stay word aligned
    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("misaligned pc %h", pc);

endmodule

`default_nettype wire

//--- hdl/riscvCore.sv
`default_nettype none

module riscvCore (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] imemData,
    input  logic [31:0] dmemRdata,
    output logic [31:0] imemAddr,
    output logic [31:0] dmemAddr,
    output logic [31:0] dmemWdata,
    output logic        dmemWe
);

    riscvPkg::instrWord        instr;
    logic [1:0]                pcSrc;
    logic [3:0]                aluOp;
    logic                      zeroFlag;
    logic                      negativeFlag;
    logic                      unsignedLess;
    logic [riscvPkg::xlen-1:0] pc;
    logic [riscvPkg::xlen-1:0] pcPlus4;
    logic [riscvPkg::xlen-1:0] imm;
    logic [riscvPkg::xlen-1:0] rdata1;
    logic [riscvPkg::xlen-1:0] rdata2;
    logic [riscvPkg::xlen-1:0] srcA;
    logic [riscvPkg::xlen-1:0] srcB;
    logic [riscvPkg::xlen-1:0] aluResult;
    logic [riscvPkg::xlen-1:0] result; // writeback value

    ctrlIf ctrlBus ();

    assign instr = imemData;

    controlUnit i_controlUnit (
        .opcode       (instr.r.opcode),
        .funct3       (instr.r.funct3),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .unsignedLess (unsignedLess),
        .rstN         (rstN),
        .ctrl         (ctrlBus.ctrl),
        .pcSrc        (pcSrc)
    );

    aluDecoder i_aluDecoder (
        .dp       (ctrlBus.dp),
        .funct3   (instr.r.funct3),
        .funct7b5 (instr.r.funct7[5]),
        .opBit5   (instr.r.opcode[5]),
        .aluOp    (aluOp)
    );

    regFile i_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rs1    (instr.r.rs1),
        .rs2    (instr.r.rs2),
        .rd     (instr.r.rd),
        .we     (ctrlBus.regWrite),
        .wdata  (result),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    immGen i_immGen (
        .instr (instr),
        .dp    (ctrlBus.dp),
        .imm   (imm)
    );

    // operand muxes
    assign srcA = ctrlBus.aluASrcPc ? pc : rdata1;
    assign srcB = ctrlBus.aluSrc ? imm : rdata2;

    alu i_alu (
        .srcA         (srcA),
        .srcB         (srcB),
        .aluOp        (aluOp),
        .result       (aluResult),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .unsignedLess (unsignedLess)
    );

    pcUnit i_pcUnit (
        .clk      (clk),
        .rstN     (rstN),
        .pcSrc    (pcSrc),
        .imm      (imm),
        .jalrBase (aluResult),
        .pc       (pc),
        .pcPlus4  (pcPlus4)
    );

    always_comb begin
        case (ctrlBus.resultSrc)
            riscvPkg::resLoad:    result = dmemRdata;
            riscvPkg::resPcPlus4: result = pcPlus4; // link
            riscvPkg::resImm:     result = imm;
            default:              result = aluResult;
        endcase
    end

    assign imemAddr  = pc;
    assign dmemAddr  = aluResult; // rs1 + offset
    assign dmemWdata = rdata2;
    assign dmemWe    = ctrlBus.memWrite;

endmodule

`default_nettype wire

//--- tb/riscvCoreTb.sv
`default_nettype none

module riscvCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int resetCycles = 10;
    localparam int progWords   = 141; // all test programs together
    localparam int numResets   = 7;
    localparam int cycleLimit  = progWords * 4 + resetCycles * numResets;

    logic        clk;
    logic        rstN;
    logic [31:0] imemAddr;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;
    logic        dmemWe;
    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] prog[$];
    logic [31:0] expAddr[$];
    logic [31:0] expData[$];
    logic [31:0] gotAddr[$];
    logic [31:0] gotData[$];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;

    riscvCore i_riscvCore (
        .clk       (clk),
        .rstN      (rstN),
        .imemData  (imem[imemAddr[9:2]]), // combinational reads
        .dmemRdata (dmem[dmemAddr[9:2]]),
        .imemAddr  (imemAddr),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemWe    (dmemWe)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("run stopped after %0d cycles, core never reached its end loop", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // store port sampled mid-cycle where it is stable
    always @(negedge clk) begin
        if (rstN && dmemWe) begin
            dmem[dmemAddr[9:2]] <= dmemWdata;
            gotAddr.push_back(dmemAddr);
            gotData.push_back(dmemWdata);
        end
    end

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr & 32'hfffffffc) * 32'h9e3779b1 ^ 32'h5a5a0000; // depends on all bits
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // RV32I result rules, alt is funct7 bit 5
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic loadConst(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = val + 32'h800; // addi sign-extends the low part
        prog.push_back({upper[31:12], rd, 7'b0110111});
        prog.push_back(encI(val[11:0], rd, 3'd0, rd, 7'b0010011));
    endtask

    task automatic storeExpect(input logic [4:0] rs2, input logic [11:0] off,
                               input logic [31:0] data);
        prog.push_back(encS(off, rs2, 5'd0));
        expAddr.push_back({20'd0, off});
        expData.push_back(data);
    endtask

    // hold reset, load program and memory, then release
    task automatic resetDut();
        @(posedge clk);
        #2 rstN = 1'b0;
        for (int k = 0; k < 256; k++) begin
            imem[k] = (k < prog.size()) ? prog[k] : 32'h00000013;
            dmem[k] = fillWord(32'(k * 4));
        end
        repeat (resetCycles) begin
            @(negedge clk);
            checkAddr("imemAddr", imemAddr, 32'd0);
            checks++;
            if (dmemWe !== 1'b0) begin
                errors++;
                $display("data memory write strobe active during reset");
            end
        end
        gotAddr.delete();
        gotData.delete();
        @(posedge clk);
        #2 rstN = 1'b1;
    endtask

    task automatic runToLoop();
        logic [31:0] loopAddr;
        loopAddr = 32'((prog.size() - 1) * 4);
        while (imemAddr !== loopAddr) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic compareStores();
        checks++;
        if (gotAddr.size() != expAddr.size()) begin
            errors++;
            $display("saw %0d stores instead of %0d", gotAddr.size(), expAddr.size());
        end else begin
            foreach (expAddr[k]) begin
                checkWord("dmemAddr", gotAddr[k], expAddr[k]);
                checkWord("dmemWdata", gotData[k], expData[k]);
            end
        end
        prog.delete();
        expAddr.delete();
        expData.delete();
    endtask

    task automatic reportTest(input string name, input int errBefore);
        tests++;
        $display("%s: %s", name, (errors == errBefore) ? "ok" : "errors");
    endtask

    task automatic testArith(input logic [31:0] a, input logic [31:0] b);
        int          errBefore;
        int          n;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] bImm;
        errBefore = errors;
        n = 0;
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5); // sub, sra last
            alt = (k >= 8);
            prog.push_back(encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
            storeExpect(5'd3, 12'(n * 4), aluRef(f3, alt, a, b));
            n++;
        end
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? 3'(k) : 3'd5; // srai last
            alt = (k == 8);
            imm = 12'($urandom);
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
            end
            bImm = {{20{imm[11]}}, imm};
            prog.push_back(encI(imm, 5'd1, f3, 5'd3, 7'b0010011));
            storeExpect(5'd3, 12'(n * 4), aluRef(f3, alt, a, bImm));
            n++;
        end
        prog.push_back(encJ(21'd0, 5'd0));
        resetDut();
        runToLoop();
        compareStores();
        reportTest("arith", errBefore);
    endtask

    task automatic testLoadStore();
        int          errBefore;
        logic [31:0] w0;
        logic [31:0] w1;
        errBefore = errors;
        w0 = fillWord(32'h100);
        w1 = fillWord(32'h104);
        prog.push_back(encI(12'h100, 5'd0, 3'd2, 5'd1, 7'b0000011));
        prog.push_back(encI(12'h104, 5'd0, 3'd2, 5'd2, 7'b0000011));
        prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        prog.push_back(encI(12'h040, 5'd0, 3'd0, 5'd4, 7'b0010011));
        prog.push_back(encS(12'h100, 5'd3, 5'd4)); // address 0x140
        prog.push_back(encI(12'hfff, 5'd1, 3'd4, 5'd5, 7'b0010011));
        prog.push_back(encS(12'h144, 5'd5, 5'd0));
        prog.push_back(encJ(21'd0, 5'd0));
        resetDut();
        runToLoop();
        checkWord("dmem[0x140]", dmem[8'h50], w0 + w1);
        checkWord("dmem[0x144]", dmem[8'h51], ~w0);
        checkWord("dmem[0x148]", dmem[8'h52], fillWord(32'h148));
        prog.delete();
        reportTest("load/store", errBefore);
    endtask

    task automatic testBranches();
        int          errBefore;
        int          untaken;
        logic [2:0]  f3s [6];
        logic [31:0] val [3];
        logic [4:0]  ra;
        logic [4:0]  rb;
        errBefore = errors;
        untaken = 0;
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        val = '{32'd0, 32'hffffffff, 32'd1}; // x0, x1 = -1, x2 = 1
        prog.push_back(encI(12'hfff, 5'd0, 3'd0, 5'd1, 7'b0010011));
        prog.push_back(encI(12'h001, 5'd0, 3'd0, 5'd2, 7'b0010011));
        for (int k = 0; k < 6; k++) begin
            for (int pass = 0; pass < 2; pass++) begin
                ra = (pass == 0) ? 5'd1 : 5'd2;
                rb = (pass == 0) ? 5'd2 : ((f3s[k] < 3'd2) ? 5'd2 : 5'd1);
                prog.push_back(encB(13'd8, rb, ra, f3s[k]));
                prog.push_back(encI(12'h001, 5'd10, 3'd0, 5'd10, 7'b0010011));
                if (!branchRef(f3s[k], val[ra], val[rb])) untaken++;
            end
        end
        storeExpect(5'd10, 12'h200, 32'(untaken));
        prog.push_back(encJ(21'd0, 5'd0));
        resetDut();
        runToLoop();
        compareStores();
        reportTest("branches", errBefore);
    endtask

    task automatic testJumps();
        int errBefore;
        errBefore = errors;
        prog.push_back(encJ(21'd12, 5'd1));                            // 0
        prog.push_back(32'h00000013);
        prog.push_back(32'h00000013);
        storeExpect(5'd1, 12'h300, 32'd4);                             // 12
        prog.push_back(encI(12'd29, 5'd0, 3'd0, 5'd5, 7'b0010011));    // 16
        prog.push_back(encI(12'd0, 5'd5, 3'd0, 5'd6, 7'b1100111));     // 20, odd sum
        prog.push_back(32'h00000013);
        storeExpect(5'd6, 12'h304, 32'd24);                            // 28
        prog.push_back(encJ(21'd0, 5'd0));
        resetDut();
        @(negedge clk); // jal executing at pc 0
        @(negedge clk);
        checkAddr("imemAddr", imemAddr, 32'd12);
        while (imemAddr !== 32'd20) @(negedge clk);
        @(negedge clk);
        checkAddr("imemAddr", imemAddr, 32'd28);
        runToLoop();
        compareStores();
        reportTest("jumps", errBefore);
    endtask

    task automatic testUpper();
        int          errBefore;
        logic [19:0] u1;
        logic [19:0] u2;
        errBefore = errors;
        u1 = 20'($urandom);
        u2 = 20'($urandom);
        prog.push_back({u1, 5'd1, 7'b0110111});
        prog.push_back({u2, 5'd2, 7'b0010111}); // auipc at 4
        storeExpect(5'd1, 12'h310, {u1, 12'd0});
        storeExpect(5'd2, 12'h314, {u2, 12'd0} + 32'd4);
        prog.push_back(encJ(21'd0, 5'd0));
        resetDut();
        runToLoop();
        compareStores();
        reportTest("upper immediates", errBefore);
    endtask

    task automatic testZeroReg();
        int errBefore;
        errBefore = errors;
        storeExpect(5'd0, 12'h324, 32'd0); // sw sits at pc 0 through reset
        prog.push_back(encI(12'd123, 5'd0, 3'd0, 5'd0, 7'b0010011));
        prog.push_back({20'habcde, 5'd0, 7'b0110111});
        storeExpect(5'd0, 12'h320, 32'd0);
        prog.push_back(encJ(21'd0, 5'd0));
        resetDut();
        runToLoop();
        compareStores();
        reportTest("reset and x0", errBefore);
    endtask

    initial begin
        rstN = 1'b0;
        void'($urandom(32'h7e19ec9b));
        testArith($urandom, $urandom);
        testArith(32'h80000000, 32'h00000001); // signed and unsigned less disagree
        testLoadStore();
        testBranches();
        testJumps();
        testUpper();
        testZeroReg();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- riscvCore.f
hdl/riscvPkg.sv
hdl/ctrlIf.sv
hdl/controlUnit.sv
hdl/aluDecoder.sv
hdl/alu.sv
hdl/regFile.sv
hdl/immGen.sv
hdl/pcUnit.sv
hdl/riscvCore.sv
tb/riscvCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the riscvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f riscvCore.f --top-module riscvCoreTb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    exit 0
fi
exit 1
